/* Bender.yml */
package:
  name: gat_transform_core

sources:
  - design/gat_cfg_pkg.sv
  - design/gat_mem_pkg.sv
  - design/gat_memory.sv
  - design/spmm_scheduler.sv
  - design/wh_accumulator.sv
  - design/feature_writeback.sv
  - design/gat_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/gat_checker.sv
      - bench/gat_tb.sv

/* bench/gat_checker.sv */
// Readback checker with expected feature model and error counters
`timescale 1ns/1ps

module gat_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  gat_mem_pkg::h_data_wr_t    h_data_wr,
  input  gat_mem_pkg::node_info_wr_t node_info_wr,
  input  gat_mem_pkg::wgt_wr_t       wgt_wr,
  input  logic                       all_loaded,
  input  logic                       gat_ready,
  input  logic                       rd_active,
  input  gat_cfg_pkg::feat_addr_t    feat_addr,
  input  gat_cfg_pkg::acc_t          feat_dout,
  output int                         error_count,
  output int                         check_count
);

  gat_mem_pkg::h_entry_t   h_copy   [gat_cfg_pkg::h_depth];
  gat_cfg_pkg::row_len_t   len_copy [gat_cfg_pkg::num_nodes];
  gat_mem_pkg::wgt_row_t   wgt_copy [gat_cfg_pkg::num_feat_in];
  logic                    seen_ready;
  logic                    pend;
  gat_cfg_pkg::feat_addr_t pend_addr;

  // Sum over the node's row of value times the weight in its column
  function automatic gat_cfg_pkg::acc_t expected_feature(input int addr);
    int                    node;
    int                    lane;
    int                    base;
    gat_cfg_pkg::acc_t     sum;
    gat_mem_pkg::h_entry_t ent;
    node = addr / gat_cfg_pkg::num_feat_out;
    lane = addr % gat_cfg_pkg::num_feat_out;
    base = 0;
    sum  = '0;
    for (int n = 0; n < node; n++) begin
      base += len_copy[n];
    end
    for (int k = 0; k < len_copy[node]; k++) begin
      ent = h_copy[base + k];
      sum += gat_cfg_pkg::acc_t'(ent.value) * gat_cfg_pkg::acc_t'(wgt_copy[ent.col][lane]);
    end
    return sum;
  endfunction

  // Copy of what the host loads
  always @(posedge clk) begin
    if (h_data_wr.en) h_copy[h_data_wr.addr] <= h_data_wr.data;
    if (node_info_wr.en) len_copy[node_info_wr.addr] <= node_info_wr.data;
    if (wgt_wr.en) wgt_copy[wgt_wr.addr] <= wgt_wr.data;
  end

  initial begin
    error_count = 0;
    check_count = 0;
    seen_ready  = 1'b0;
    pend        = 1'b0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (gat_ready && !all_loaded) begin
        error_count++;
        $display("error at %0t ns: gat_ready is 1, expected 0 while loads are pending", $time);
      end
      if (seen_ready && !gat_ready) begin
        error_count++;
        $display("error at %0t ns: gat_ready is 0, expected 1 once raised", $time);
      end
      seen_ready = seen_ready || gat_ready;
      // Data for the address seen one edge earlier
      if (pend) begin
        check_count++;
        if (feat_dout !== expected_feature(pend_addr)) begin
          error_count++;
          $display("error at %0t ns: feat_dout[%0d] is %0d, expected %0d",
                   $time, pend_addr, feat_dout, expected_feature(pend_addr));
        end
      end
      pend      = rd_active;
      pend_addr = feat_addr;
    end
  end

endmodule

/* bench/gat_tb.sv */
// Bench top with stimulus tables, memory load, readback loop and watchdog
`timescale 1ns/1ps

module gat_tb;

  localparam int n_entries      = 31;
  localparam int wgt_fixed_rows = 6;
  localparam int clk_period     = 8;
  localparam int feat_depth     = gat_cfg_pkg::feat_depth;
  // Each gap outlasts a full pass over all nodes
  localparam int level_gap      = 8 * n_entries;
  localparam int load_cycles    = 5 + n_entries + gat_cfg_pkg::num_nodes +
                                  gat_cfg_pkg::num_feat_in + 2 * level_gap + 8 +
                                  2 * feat_depth;
  localparam int watchdog_cycles = 40 * n_entries + load_cycles;

  // One stored nonzero per word in row order
  typedef struct packed {
    logic [3:0]          node;
    logic [3:0]          col;
    gat_cfg_pkg::value_t value;
  } stim_entry_t;

  // Node 2 empty, nodes 0 and 4 single, nodes 3 and 7 full of 255, node 5 full length
  localparam logic [15:0] stim_tab [n_entries] = '{
    16'h0305, 16'h100C, 16'h12C8, 16'h1507,
    16'h30FF, 16'h31FF, 16'h32FF, 16'h33FF, 16'h34FF, 16'h35FF, 16'h36FF, 16'h37FF,
    16'h47FF,
    16'h5001, 16'h5110, 16'h5222, 16'h5340, 16'h5480, 16'h55A5, 16'h56C3, 16'h57E1,
    16'h6101, 16'h6663,
    16'h70FF, 16'h71FF, 16'h72FF, 16'h73FF, 16'h74FF, 16'h75FF, 16'h76FF, 16'h77FF
  };

  // W rows with lane 0 in the low byte
  localparam logic [31:0] wgt_fixed [wgt_fixed_rows] = '{
    32'h01020304, 32'hFFFFFFFF, 32'h001080FF, 32'hFF007F01, 32'hFF55AA00, 32'hFFC02009
  };

  logic                       clk;
  logic                       rst_n;
  gat_mem_pkg::h_data_wr_t    h_data_wr;
  gat_mem_pkg::node_info_wr_t node_info_wr;
  gat_mem_pkg::wgt_wr_t       wgt_wr;
  logic                       h_data_load_done;
  logic                       node_info_load_done;
  logic                       wgt_load_done;
  gat_cfg_pkg::feat_addr_t    feat_addr;
  gat_cfg_pkg::acc_t          feat_dout;
  logic                       gat_ready;
  logic                       rd_active;
  int                         error_count;
  int                         check_count;
  integer                     seed;
  gat_cfg_pkg::row_len_t      row_len [gat_cfg_pkg::num_nodes];
  gat_mem_pkg::wgt_row_t      wgt_tab [gat_cfg_pkg::num_feat_in];

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  gat_top dut (.*);

  gat_checker u_checker (
    .clk(clk), .rst_n(rst_n), .h_data_wr(h_data_wr), .node_info_wr(node_info_wr),
    .wgt_wr(wgt_wr), .all_loaded(h_data_load_done && node_info_load_done && wgt_load_done),
    .gat_ready(gat_ready), .rd_active(rd_active), .feat_addr(feat_addr),
    .feat_dout(feat_dout), .error_count(error_count), .check_count(check_count)
  );

  task automatic build_tables();
    stim_entry_t ent;
    for (int n = 0; n < gat_cfg_pkg::num_nodes; n++) row_len[n] = '0;
    for (int i = 0; i < n_entries; i++) begin
      ent = stim_entry_t'(stim_tab[i]);
      row_len[ent.node] = row_len[ent.node] + 1'b1;
    end
    for (int r = 0; r < gat_cfg_pkg::num_feat_in; r++) begin
      if (r < wgt_fixed_rows) wgt_tab[r] = wgt_fixed[r];
      else wgt_tab[r] = $random(seed);
    end
  endtask

  task automatic load_memories();
    stim_entry_t ent;
    for (int i = 0; i < n_entries; i++) begin
      ent = stim_entry_t'(stim_tab[i]);
      @(posedge clk);
      h_data_wr <= '{en: 1'b1, addr: gat_cfg_pkg::h_addr_t'(i),
                     data: '{value: ent.value, col: gat_cfg_pkg::col_t'(ent.col)}};
    end
    for (int n = 0; n < gat_cfg_pkg::num_nodes; n++) begin
      @(posedge clk);
      h_data_wr.en <= 1'b0;
      node_info_wr <= '{en: 1'b1, addr: gat_cfg_pkg::node_t'(n), data: row_len[n]};
    end
    for (int r = 0; r < gat_cfg_pkg::num_feat_in; r++) begin
      @(posedge clk);
      node_info_wr.en <= 1'b0;
      wgt_wr <= '{en: 1'b1, addr: gat_cfg_pkg::col_t'(r), data: wgt_tab[r]};
    end
    @(posedge clk);
    wgt_wr.en <= 1'b0;
  endtask

  task automatic read_features();
    for (int a = 0; a < feat_depth; a++) begin
      @(posedge clk);
      feat_addr <= gat_cfg_pkg::feat_addr_t'(a);
      rd_active <= 1'b1;
    end
    @(posedge clk);
    rd_active <= 1'b0;
  endtask

  initial begin
    h_data_wr           = '0;
    node_info_wr        = '0;
    wgt_wr              = '0;
    h_data_load_done    = 1'b0;
    node_info_load_done = 1'b0;
    wgt_load_done       = 1'b0;
    feat_addr           = '0;
    rd_active           = 1'b0;
    seed                = 62209;
    build_tables();
    @(posedge rst_n);
    load_memories();
    // Levels rise one at a time while gat_ready stays low
    @(posedge clk);
    h_data_load_done <= 1'b1;
    repeat (level_gap) @(posedge clk);
    node_info_load_done <= 1'b1;
    repeat (level_gap) @(posedge clk);
    wgt_load_done <= 1'b1;
    wait (gat_ready === 1'b1);
    read_features();
    repeat (4) @(posedge clk);
    if (check_count != feat_depth) begin
      $display("readback incomplete: %0d of %0d features were checked", check_count, feat_depth);
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && check_count == feat_depth) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ==========================================================================
  // Watchdog
  // ==========================================================================
  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
    $display("checks %0d, errors %0d", check_count, error_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
// Bench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam real half_period  = 4.0;
  localparam int  reset_cycles = 5;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #(half_period) clk = ~clk;

endmodule

/* design/feature_writeback.sv */
// Serializer of node vectors into feature memory writes
`timescale 1ns/1ps

module feature_writeback (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  vec_valid,
  input  gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] vec,
  output gat_mem_pkg::feat_wr_t feat_wr,
  output logic                  wb_done
);

  gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] vec_q;

  logic               busy;
  gat_cfg_pkg::node_t node_q;
  gat_cfg_pkg::lane_t lane;
  logic               last_lane;

  assign last_lane = (lane == gat_cfg_pkg::lane_t'(gat_cfg_pkg::num_feat_out - 1));

  // Address is node * num_feat_out + lane
  always_comb begin
    feat_wr.en   = busy;
    feat_wr.addr = gat_cfg_pkg::feat_addr_t'(node_q) *
                   gat_cfg_pkg::feat_addr_t'(gat_cfg_pkg::num_feat_out) +
                   gat_cfg_pkg::feat_addr_t'(lane);
    feat_wr.data = vec_q[lane];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      node_q  <= '0;
      lane    <= '0;
      wb_done <= 1'b0;
    end else begin
      wb_done <= busy && last_lane;
      if (vec_valid) begin
        busy <= 1'b1;
        lane <= '0;
      end else if (busy) begin
        lane <= lane + 1'b1;
        if (last_lane) begin
          busy   <= 1'b0;
          node_q <= node_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vec_valid) vec_q <= vec;
  end

endmodule

/* design/gat_cfg_pkg.sv */
// Graph and matrix dimensions, derived widths and value typedefs
package gat_cfg_pkg;

  // ==========================================================================
  // Dimensions
  // ==========================================================================
  localparam int num_nodes    = 8;
  localparam int num_feat_in  = 8;
  localparam int num_feat_out = 4;
  localparam int h_depth      = 32;
  localparam int feat_depth   = num_nodes * num_feat_out;

  localparam int data_w = 8;
  // Holds num_feat_in products of two full-scale values
  localparam int acc_w  = 20;

  // Derived widths
  localparam int col_w       = $clog2(num_feat_in);
  localparam int node_w      = $clog2(num_nodes);
  localparam int row_len_w   = $clog2(num_feat_in + 1);
  localparam int h_addr_w    = $clog2(h_depth);
  localparam int feat_addr_w = $clog2(feat_depth);
  localparam int lane_w      = $clog2(num_feat_out);

  // ==========================================================================
  // Value types
  // ==========================================================================
  typedef logic [data_w-1:0]      value_t;
  typedef logic [col_w-1:0]       col_t;
  typedef logic [node_w-1:0]      node_t;
  typedef logic [row_len_w-1:0]   row_len_t;
  typedef logic [h_addr_w-1:0]    h_addr_t;
  typedef logic [feat_addr_w-1:0] feat_addr_t;
  typedef logic [lane_w-1:0]      lane_t;
  typedef logic [acc_w-1:0]       acc_t;

endpackage

/* design/gat_mem_pkg.sv */
// Memory record formats and host write-port structs
package gat_mem_pkg;

  // ==========================================================================
  // Stored records
  // ==========================================================================

  // One nonzero of H
  typedef struct packed {
    gat_cfg_pkg::value_t value;
    gat_cfg_pkg::col_t   col;
  } h_entry_t;

  // Whole W row, lane 0 in the low bits
  typedef gat_cfg_pkg::value_t [gat_cfg_pkg::num_feat_out-1:0] wgt_row_t;

  // ==========================================================================
  // Write ports
  // ==========================================================================
  typedef struct packed {
    logic                   en;
    gat_cfg_pkg::h_addr_t   addr;
    h_entry_t               data;
  } h_data_wr_t;

  typedef struct packed {
    logic                   en;
    gat_cfg_pkg::node_t     addr;
    gat_cfg_pkg::row_len_t  data;
  } node_info_wr_t;

  typedef struct packed {
    logic                   en;
    gat_cfg_pkg::col_t      addr;
    wgt_row_t               data;
  } wgt_wr_t;

  // Core side, one output feature per write
  typedef struct packed {
    logic                    en;
    gat_cfg_pkg::feat_addr_t addr;
    gat_cfg_pkg::acc_t       data;
  } feat_wr_t;

endpackage

/* design/gat_memory.sv */
// Block memories for H entries, row lengths, weights and output features
`timescale 1ns/1ps

module gat_memory (
  input  logic                       clk,
  input  logic                       rst_n,

  input  gat_mem_pkg::h_data_wr_t    h_data_wr,
  input  gat_mem_pkg::node_info_wr_t node_info_wr,
  input  gat_mem_pkg::wgt_wr_t       wgt_wr,
  input  gat_mem_pkg::feat_wr_t      feat_wr,

  input  gat_cfg_pkg::h_addr_t       h_addr,
  output gat_mem_pkg::h_entry_t      h_entry,
  input  gat_cfg_pkg::node_t         node_info_addr,
  output gat_cfg_pkg::row_len_t      node_row_len,
  input  gat_cfg_pkg::col_t          wgt_addr,
  output gat_mem_pkg::wgt_row_t      wgt_row,
  input  gat_cfg_pkg::feat_addr_t    feat_addr,
  output gat_cfg_pkg::acc_t          feat_dout
);

  gat_mem_pkg::h_entry_t h_mem    [gat_cfg_pkg::h_depth];
  gat_cfg_pkg::row_len_t info_mem [gat_cfg_pkg::num_nodes];
  gat_mem_pkg::wgt_row_t wgt_mem  [gat_cfg_pkg::num_feat_in];
  gat_cfg_pkg::acc_t     feat_mem [gat_cfg_pkg::feat_depth];

  // ==========================================================================
  // Write side
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (h_data_wr.en) begin
      h_mem[h_data_wr.addr] <= h_data_wr.data;
    end
    if (node_info_wr.en) begin
      info_mem[node_info_wr.addr] <= node_info_wr.data;
    end
    if (wgt_wr.en) begin
      wgt_mem[wgt_wr.addr] <= wgt_wr.data;
    end
    // Written by the core, read by the host
    if (feat_wr.en) begin
      feat_mem[feat_wr.addr] <= feat_wr.data;
    end
  end

  // ==========================================================================
  // Read side, one cycle latency
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_entry      <= '0;
      node_row_len <= '0;
      wgt_row      <= '0;
      feat_dout    <= '0;
    end else begin
      h_entry      <= h_mem[h_addr];
      node_row_len <= info_mem[node_info_addr];
      wgt_row      <= wgt_mem[wgt_addr];
      feat_dout    <= feat_mem[feat_addr];
    end
  end

endmodule

/* design/gat_top.sv */
// Top level of the sparse feature transform core
`timescale 1ns/1ps

module gat_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  gat_mem_pkg::h_data_wr_t    h_data_wr,
  input  gat_mem_pkg::node_info_wr_t node_info_wr,
  input  gat_mem_pkg::wgt_wr_t       wgt_wr,
  input  logic                       h_data_load_done,
  input  logic                       node_info_load_done,
  input  logic                       wgt_load_done,
  input  gat_cfg_pkg::feat_addr_t    feat_addr,
  output gat_cfg_pkg::acc_t          feat_dout,
  output logic                       gat_ready
);

  gat_cfg_pkg::h_addr_t  h_addr;
  gat_mem_pkg::h_entry_t h_entry;
  gat_cfg_pkg::node_t    node_info_addr;
  gat_cfg_pkg::row_len_t node_row_len;
  gat_cfg_pkg::col_t     wgt_addr;
  gat_mem_pkg::wgt_row_t wgt_row;
  gat_mem_pkg::feat_wr_t feat_wr;
  logic                  h_valid;
  logic                  h_last;
  logic                  row_empty;
  logic                  vec_valid;
  logic                  wb_done;

  gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] vec;

  // ==========================================================================
  // Memories and datapath
  // ==========================================================================
  gat_memory u_gat_memory (.*);

  spmm_scheduler u_spmm_scheduler (.*);

  wh_accumulator u_wh_accumulator (.*);

  feature_writeback u_feature_writeback (.*);

endmodule

/* design/spmm_scheduler.sv */
// Node walker FSM issuing H reads and raising gat_ready
`timescale 1ns/1ps

module spmm_scheduler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  h_data_load_done,
  input  logic                  node_info_load_done,
  input  logic                  wgt_load_done,
  output gat_cfg_pkg::node_t    node_info_addr,
  input  gat_cfg_pkg::row_len_t node_row_len,
  output gat_cfg_pkg::h_addr_t  h_addr,
  output logic                  h_valid,
  output logic                  h_last,
  output logic                  row_empty,
  input  logic                  wb_done,
  output logic                  gat_ready
);

  typedef enum logic [2:0] {
    S_WAIT_LOAD,
    S_FETCH_INFO,
    S_STREAM,
    S_WAIT_WB,
    S_DONE
  } state_t;

  state_t                state;
  gat_cfg_pkg::node_t    node_idx;
  logic                  last_node;
  gat_cfg_pkg::h_addr_t  h_ptr;
  gat_cfg_pkg::row_len_t rows_left;
  logic                  all_loaded;
  logic                  row_finish;

  assign all_loaded = h_data_load_done && node_info_load_done && wgt_load_done;

  // Empty row at info fetch, or final entry going out
  assign row_finish = (state == S_FETCH_INFO && node_row_len == '0) ||
                      (state == S_STREAM && rows_left == gat_cfg_pkg::row_len_t'(1));

  assign node_info_addr = node_idx;
  assign h_addr         = h_ptr;
  assign gat_ready      = (state == S_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_WAIT_LOAD;
      node_idx  <= '0;
      last_node <= 1'b0;
      h_ptr     <= '0;
      rows_left <= '0;
      h_valid   <= 1'b0;
      h_last    <= 1'b0;
      row_empty <= 1'b0;
    end else begin
      h_valid   <= 1'b0;
      h_last    <= 1'b0;
      row_empty <= 1'b0;

      // Next row length is read while the current node writes back
      if (row_finish) begin
        node_idx  <= node_idx + 1'b1;
        last_node <= (node_idx == gat_cfg_pkg::node_t'(gat_cfg_pkg::num_nodes - 1));
      end

      case (state)
        S_WAIT_LOAD: begin
          if (all_loaded) state <= S_FETCH_INFO;
        end
        S_FETCH_INFO: begin
          rows_left <= node_row_len;
          if (node_row_len == '0) begin
            row_empty <= 1'b1;
            state     <= S_WAIT_WB;
          end else begin
            state <= S_STREAM;
          end
        end
        S_STREAM: begin
          // h_valid and h_last line up with the registered h_entry
          h_valid   <= 1'b1;
          h_last    <= row_finish;
          h_ptr     <= h_ptr + 1'b1;
          rows_left <= rows_left - 1'b1;
          if (row_finish) state <= S_WAIT_WB;
        end
        S_WAIT_WB: begin
          if (wb_done) state <= last_node ? S_DONE : S_FETCH_INFO;
        end
        S_DONE: begin
          state <= S_DONE;
        end
        default: state <= S_WAIT_LOAD;
      endcase
    end
  end

endmodule

/* design/wh_accumulator.sv */
// Weight-row fetch and multiply-accumulate pipeline
`timescale 1ns/1ps

module wh_accumulator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gat_mem_pkg::h_entry_t h_entry,
  input  logic                  h_valid,
  input  logic                  h_last,
  input  logic                  row_empty,
  output gat_cfg_pkg::col_t     wgt_addr,
  input  gat_mem_pkg::wgt_row_t wgt_row,
  output logic                  vec_valid,
  output gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] vec
);

  logic                s1_valid;
  logic                s1_last;
  gat_cfg_pkg::value_t s1_value;

  gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] lanes;
  gat_cfg_pkg::acc_t [gat_cfg_pkg::num_feat_out-1:0] sums;

  // Column index selects the W row
  assign wgt_addr = h_entry.col;

  // ==========================================================================
  // Multiply-accumulate, one lane per output feature
  // ==========================================================================
  always_comb begin
    for (int i = 0; i < gat_cfg_pkg::num_feat_out; i++) begin
      sums[i] = lanes[i] + gat_cfg_pkg::acc_t'(s1_value) * gat_cfg_pkg::acc_t'(wgt_row[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_last   <= 1'b0;
      vec_valid <= 1'b0;
      lanes     <= '0;
    end else begin
      s1_valid  <= h_valid;
      s1_last   <= h_valid && h_last;
      vec_valid <= s1_last || row_empty;
      // Lanes restart for the next node once its vector leaves
      if (s1_last || row_empty) begin
        lanes <= '0;
      end else if (s1_valid) begin
        lanes <= sums;
      end
    end
  end

  // Value waits here while its weight row is read
  always_ff @(posedge clk) begin
    if (h_valid) begin
      s1_value <= h_entry.value;
    end
    if (s1_last) begin
      vec <= sums;
    end else if (row_empty) begin
      vec <= '0;
    end
  end

endmodule

/* flist.f */
design/gat_cfg_pkg.sv
design/gat_mem_pkg.sv
design/gat_memory.sv
design/spmm_scheduler.sv
design/wh_accumulator.sv
design/feature_writeback.sv
design/gat_top.sv
bench/tb_clock.sv
bench/gat_checker.sv
bench/gat_tb.sv
